// File: logger_cfg.svh
`ifndef LOGGER_CFG_SVH
`define LOGGER_CFG_SVH

////////////////////
// Serial timing
////////////////////

// UART bit time in clk cycles
// kept short so simulation stays fast
`define LOGGER_CLKS_PER_BIT 8

// ADC serial clock period in clk cycles, half low then half high
`define LOGGER_SCLK_DIV 4

////////////////////
// Storage sizes
////////////////////

// One ADC conversion
`define LOGGER_SAMPLE_W 10
// 16 entries in the sample memory
`define LOGGER_ADDR_W 4

`endif

// File: logger_pkg.sv
`default_nettype none

`include "logger_cfg.svh"

package logger_pkg;

    ////////////////////
    // Command types
    ////////////////////

    // Decoded command kind
    typedef enum logic [1:0] {
        OP_SAMPLE,
        OP_READ,
        OP_BAD
    } cmd_op_e;

    ////////////////////
    // Payload types
    ////////////////////

    // One ADC sample as stored in memory
    typedef logic [`LOGGER_SAMPLE_W-1:0] sample_t;

    // Sample memory index
    typedef logic [`LOGGER_ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// File: logger_if.sv
`timescale 1ns/1ps
`default_nettype none

// Handshake link between pipeline stages
// Transfer when valid and ready are both high
interface stage_if;
    logic                  valid;
    logic                  ready;
    logger_pkg::cmd_op_e   op;
    logger_pkg::addr_t     addr;
    logger_pkg::sample_t   data;

    // Upstream side, payload held while stalled
    modport src (output valid, op, addr, data, input ready);
    // Downstream side
    modport dst (input valid, op, addr, data, output ready);
endinterface

// Wishbone classic link to the sample memory
interface wb_if;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logger_pkg::addr_t     adr;
    logger_pkg::sample_t   dat_w;
    logger_pkg::sample_t   dat_r;
    logic                  ack;

    // Master holds cyc and stb until ack
    modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);
    // Slave answers with a one cycle ack
    modport slave (input cyc, stb, we, adr, dat_w, output dat_r, ack);
endinterface

`default_nettype wire

// File: uart_phy.sv
`timescale 1ns/1ps
`default_nettype none

`include "logger_cfg.svh"

////////////////////
// UART receiver
////////////////////

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_strobe
);
    localparam int clks_per_bit = `LOGGER_CLKS_PER_BIT;
    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);
    localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [cnt_w-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;

    // Two flop synchronizer, idle line is high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RX_IDLE;
            cnt       <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    // Falling edge marks a start bit
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (cnt == half_last) begin
                        // Still low at mid-bit, else a glitch
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == bit_last) begin
                        cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == bit_last) begin
                        // Bad stop bit drops the byte
                        rx_strobe <= rx_sync;
                        state     <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first, sampled at mid-bit
    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == bit_last) begin
            shift <= {rx_sync, shift[7:1]};
        end
        if (state == RX_STOP && cnt == bit_last) begin
            rx_data <= shift;
        end
    end
endmodule

////////////////////
// UART transmitter
////////////////////

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_data,
    input  logic       tx_send,
    output logic       tx,
    output logic       tx_busy
);
    localparam int clks_per_bit = `LOGGER_CLKS_PER_BIT;
    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);

    logic [cnt_w-1:0] cnt;
    logic [3:0]       bit_idx;
    // Data bits then the stop bit
    logic [8:0]       shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            cnt     <= '0;
            bit_idx <= '0;
            if (tx_send) begin
                // Start bit goes out right away
                tx      <= 1'b0;
                tx_busy <= 1'b1;
                shift   <= {1'b1, tx_data};
            end
        end else if (cnt == bit_last) begin
            cnt <= '0;
            if (bit_idx == 4'd9) begin
                // Stop bit done, line already high
                tx_busy <= 1'b0;
            end else begin
                tx      <= shift[0];
                shift   <= {1'b1, shift[8:1]};
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end
endmodule

`default_nettype wire

// File: adc_sampler.sv
`timescale 1ns/1ps
`default_nettype none

`include "logger_cfg.svh"

module adc_sampler (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    output logic                done,
    output logger_pkg::sample_t sample,
    output logic                adc_cs,
    output logic                adc_sclk,
    input  logic                adc_data
);
    localparam int sclk_div = `LOGGER_SCLK_DIV;
    localparam int frame_bits = `LOGGER_SAMPLE_W;
    localparam int div_w = $clog2(sclk_div);
    localparam int bit_w = $clog2(frame_bits);

    // Low half first, then high half of each serial clock period
    localparam logic [div_w-1:0] half_div = div_w'(sclk_div / 2);
    localparam logic [div_w-1:0] rise_cnt = div_w'(sclk_div / 2 - 1);
    localparam logic [div_w-1:0] div_last = div_w'(sclk_div - 1);
    localparam logic [bit_w-1:0] bit_last = bit_w'(frame_bits - 1);

    logic             active;
    logic [div_w-1:0] div_cnt;
    logic [bit_w-1:0] bit_cnt;

    // Chip select low for the whole frame
    assign adc_cs = !active;
    assign adc_sclk = active && (div_cnt >= half_div);

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            done    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (!active) begin
                div_cnt <= '0;
                bit_cnt <= '0;
                active  <= start;
            end else if (div_cnt == div_last) begin
                div_cnt <= '0;
                // Tenth period ends the frame, cs rises with done
                if (bit_cnt == bit_last) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Capture on the edge where sclk rises, MSB first
    // Only shifts inside a frame so the result holds after done
    always_ff @(posedge clk) begin
        if (active && div_cnt == rise_cnt) begin
            sample <= {sample[frame_bits-2:0], adc_data};
        end
    end
endmodule

`default_nettype wire

// File: cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_strobe,
    stage_if.src       cmd
);
    // Opcode bytes from the host
    localparam logic [7:0] byte_sample = 8'h53;
    localparam logic [7:0] byte_read = 8'h52;

    typedef enum logic [1:0] {DC_OP, DC_ADDR, DC_HOLD} dc_state_e;

    dc_state_e state;

    // Command waits here until execute takes it
    assign cmd.valid = (state == DC_HOLD);
    assign cmd.data = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DC_OP;
        end else begin
            case (state)
                DC_OP: begin
                    if (rx_strobe) begin
                        // Unknown byte needs no address
                        if (rx_data == byte_sample || rx_data == byte_read) begin
                            state <= DC_ADDR;
                        end else begin
                            state <= DC_HOLD;
                        end
                    end
                end
                DC_ADDR: begin
                    if (rx_strobe) begin
                        state <= DC_HOLD;
                    end
                end
                default: begin
                    // Incoming bytes are dropped while held
                    if (cmd.ready) begin
                        state <= DC_OP;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DC_OP && rx_strobe) begin
            case (rx_data)
                byte_sample: cmd.op <= logger_pkg::OP_SAMPLE;
                byte_read:   cmd.op <= logger_pkg::OP_READ;
                default: begin
                    cmd.op   <= logger_pkg::OP_BAD;
                    cmd.addr <= '0;
                end
            endcase
        end
        // High address bits wrap away
        if (state == DC_ADDR && rx_strobe) begin
            cmd.addr <= logger_pkg::addr_t'(rx_data);
        end
    end
endmodule

`default_nettype wire

// File: cmd_execute.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_execute (
    input  logic                clk,
    input  logic                rst,
    stage_if.dst                cmd,
    stage_if.src                res,
    wb_if.master                mem,
    output logic                adc_start,
    input  logic                adc_done,
    input  logger_pkg::sample_t adc_sample
);
    typedef enum logic [1:0] {EX_IDLE, EX_ADC, EX_BUS, EX_RESULT} ex_state_e;

    ex_state_e           state;
    logic                bus_q;
    logic                we_q;
    logger_pkg::cmd_op_e op_q;
    logger_pkg::addr_t   addr_q;
    logger_pkg::sample_t data_q;

    ////////////////////
    // Stage handshakes
    ////////////////////

    assign cmd.ready = (state == EX_IDLE);
    assign res.valid = (state == EX_RESULT);
    assign res.op = op_q;
    assign res.addr = addr_q;
    assign res.data = data_q;

    // Single strobe per cycle, cyc and stb move together
    assign mem.cyc = bus_q;
    assign mem.stb = bus_q;
    assign mem.we = we_q;
    assign mem.adr = addr_q;
    assign mem.dat_w = data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= EX_IDLE;
            bus_q     <= 1'b0;
            adc_start <= 1'b0;
        end else begin
            adc_start <= 1'b0;
            case (state)
                EX_IDLE: begin
                    if (cmd.valid) begin
                        case (cmd.op)
                            logger_pkg::OP_SAMPLE: begin
                                adc_start <= 1'b1;
                                state     <= EX_ADC;
                            end
                            logger_pkg::OP_READ: begin
                                bus_q <= 1'b1;
                                state <= EX_BUS;
                            end
                            // Bad opcode goes straight to the reply
                            default: state <= EX_RESULT;
                        endcase
                    end
                end
                EX_ADC: begin
                    // Write cycle starts once the frame is in
                    if (adc_done) begin
                        bus_q <= 1'b1;
                        state <= EX_BUS;
                    end
                end
                EX_BUS: begin
                    if (mem.ack) begin
                        bus_q <= 1'b0;
                        state <= EX_RESULT;
                    end
                end
                default: begin
                    // Result held until the reply stage is free
                    if (res.ready) begin
                        state <= EX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == EX_IDLE && cmd.valid) begin
            op_q   <= cmd.op;
            addr_q <= cmd.addr;
            data_q <= '0;
            we_q   <= (cmd.op == logger_pkg::OP_SAMPLE);
        end
        if (state == EX_ADC && adc_done) begin
            data_q <= adc_sample;
        end
        // Read data valid with ack
        if (state == EX_BUS && mem.ack && !we_q) begin
            data_q <= mem.dat_r;
        end
    end
endmodule

`default_nettype wire

// File: sample_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sample_ram (
    input  logic clk,
    input  logic rst,
    wb_if.slave  bus
);
    localparam int depth = 1 << $bits(logger_pkg::addr_t);

    logger_pkg::sample_t mem [depth];
    logic                req;

    // New request only, the ack cycle still sees stb high
    assign req = bus.cyc && bus.stb && !bus.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req;
        end
    end

    // Storage and read data, registered with the ack
    always_ff @(posedge clk) begin
        if (req && bus.we) begin
            mem[bus.adr] <= bus.dat_w;
        end
        if (req) begin
            bus.dat_r <= mem[bus.adr];
        end
    end
endmodule

`default_nettype wire

// File: reply_result.sv
`timescale 1ns/1ps
`default_nettype none

module reply_result (
    input  logic       clk,
    input  logic       rst,
    stage_if.dst       res,
    output logic [7:0] tx_data,
    output logic       tx_send,
    input  logic       tx_busy
);
    // Reply characters
    localparam logic [7:0] reply_ok = 8'h4B;
    localparam logic [7:0] reply_bad = 8'h3F;

    typedef enum logic [1:0] {RP_IDLE, RP_SEND, RP_HAND} rp_state_e;

    rp_state_e   state;
    logic        more_q;
    logic [7:0]  first_q;
    logic [7:0]  second_q;
    logic [15:0] read_word;

    // Zero padded sample, high byte goes first
    assign read_word = 16'(res.data);
    assign res.ready = (state == RP_IDLE);
    assign tx_data = first_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RP_IDLE;
            tx_send <= 1'b0;
            more_q  <= 1'b0;
        end else begin
            tx_send <= 1'b0;
            case (state)
                RP_IDLE: begin
                    if (res.valid) begin
                        more_q <= (res.op == logger_pkg::OP_READ);
                        state  <= RP_SEND;
                    end
                end
                RP_SEND: begin
                    // Wait out the previous byte
                    if (!tx_busy) begin
                        tx_send <= 1'b1;
                        state   <= RP_HAND;
                    end
                end
                default: begin
                    // Busy high means the byte was taken
                    if (tx_busy) begin
                        more_q <= 1'b0;
                        state  <= more_q ? RP_SEND : RP_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RP_IDLE && res.valid) begin
            case (res.op)
                logger_pkg::OP_SAMPLE: first_q <= reply_ok;
                logger_pkg::OP_READ: begin
                    first_q  <= read_word[15:8];
                    second_q <= read_word[7:0];
                end
                default: first_q <= reply_bad;
            endcase
        end
        if (state == RP_HAND && tx_busy) begin
            first_q <= second_q;
        end
    end
endmodule

`default_nettype wire

// File: logger_top.sv
`timescale 1ns/1ps
`default_nettype none

module logger_top (
    input  logic clk,
    input  logic rst,
    input  logic uart_rx_in,
    output logic uart_tx_out,
    output logic adc_cs,
    output logic adc_sclk,
    input  logic adc_data
);
    logic [7:0]          rx_data;
    logic                rx_strobe;
    logic [7:0]          tx_data;
    logic                tx_send;
    logic                tx_busy;
    logic                adc_start;
    logic                adc_done;
    logger_pkg::sample_t adc_sample;

    ////////////////////
    // Internal links
    ////////////////////

    // Decode to execute, execute to reply
    stage_if cmd_link ();
    stage_if res_link ();
    wb_if    mem_bus ();

    ////////////////////
    // Serial host side
    ////////////////////

    uart_rx uart_rx_inst (
        .clk       (clk),
        .rst       (rst),
        .rx        (uart_rx_in),
        .rx_data   (rx_data),
        .rx_strobe (rx_strobe)
    );

    cmd_decode cmd_decode_inst (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_strobe (rx_strobe),
        .cmd       (cmd_link.src)
    );

    // Command engine with ADC and memory
    cmd_execute cmd_execute_inst (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd_link.dst),
        .res        (res_link.src),
        .mem        (mem_bus.master),
        .adc_start  (adc_start),
        .adc_done   (adc_done),
        .adc_sample (adc_sample)
    );

    adc_sampler adc_sampler_inst (
        .clk      (clk),
        .rst      (rst),
        .start    (adc_start),
        .done     (adc_done),
        .sample   (adc_sample),
        .adc_cs   (adc_cs),
        .adc_sclk (adc_sclk),
        .adc_data (adc_data)
    );

    sample_ram sample_ram_inst (
        .clk (clk),
        .rst (rst),
        .bus (mem_bus.slave)
    );

    // Replies back to the host
    reply_result reply_result_inst (
        .clk     (clk),
        .rst     (rst),
        .res     (res_link.dst),
        .tx_data (tx_data),
        .tx_send (tx_send),
        .tx_busy (tx_busy)
    );

    uart_tx uart_tx_inst (
        .clk     (clk),
        .rst     (rst),
        .tx_data (tx_data),
        .tx_send (tx_send),
        .tx      (uart_tx_out),
        .tx_busy (tx_busy)
    );
endmodule

`default_nettype wire

// File: tb_logger.sv
`timescale 1ns/1ps
`default_nettype none

`include "logger_cfg.svh"

////////////////////
// Clock source
////////////////////

// 20 ns period
module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end
endmodule

////////////////////
// Testbench top
////////////////////

module tb_logger;
    localparam int clks_per_bit = `LOGGER_CLKS_PER_BIT;
    localparam int sclk_div = `LOGGER_SCLK_DIV;
    localparam int sample_w = `LOGGER_SAMPLE_W;
    // Five hex words per pattern line
    localparam int line_words = 5;
    localparam int max_lines = 32;
    // Sample then read, per random pair
    localparam int random_pairs = 4;

    logic clk;
    logic rst;
    logic uart_rx_in;
    logic uart_tx_out;
    logic adc_cs;
    logic adc_sclk;
    logic adc_data;

    logic [15:0]         patterns [line_words*max_lines];
    logger_pkg::sample_t model_mem [16];
    logger_pkg::sample_t adc_value;
    logger_pkg::sample_t rand_sample;
    logic [7:0]          reply_q [$];
    int                  frame_count;
    int                  sclk_rises;
    int                  cycle_count;
    int                  cycle_limit;
    int                  fixed_count;
    int                  line_idx;
    int                  pair_idx;
    integer              seed;
    integer              rand_addr;

    tb_clock clock_gen (
        .clk (clk)
    );

    logger_top logger_top_inst (
        .clk         (clk),
        .rst         (rst),
        .uart_rx_in  (uart_rx_in),
        .uart_tx_out (uart_tx_out),
        .adc_cs      (adc_cs),
        .adc_sclk    (adc_sclk),
        .adc_data    (adc_data)
    );

    ////////////////////
    // Failure handling
    ////////////////////

    task automatic stop_on_failure();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    task automatic check_reply(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected 0x%02h, actual 0x%02h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_sample(input string name, input logger_pkg::sample_t expected,
                                input logger_pkg::sample_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected 0x%03h, actual 0x%03h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERROR at %0t: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %b, actual %b", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    // Quiet outputs: line idle, chip deselected, serial clock low
    task automatic check_idle_levels();
        check_level("uart_tx_out", 1'b1, uart_tx_out);
        check_level("adc_cs", 1'b1, adc_cs);
        check_level("adc_sclk", 1'b0, adc_sclk);
    endtask

    ////////////////////
    // Host side UART
    ////////////////////

    // 8N1, LSB first, each bit one full bit time
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        int         bit_idx;
        frame = {1'b1, value, 1'b0};
        for (bit_idx = 0; bit_idx < 10; bit_idx++) begin
            @(posedge clk);
            #2;
            uart_rx_in = frame[bit_idx];
            repeat (clks_per_bit - 1) @(posedge clk);
        end
    endtask

    // Reply bytes sampled mid-bit on the falling clock
    always begin : reply_capture
        logic [7:0] captured;
        int         bit_idx;
        @(negedge uart_tx_out);
        repeat (clks_per_bit / 2) @(negedge clk);
        if (uart_tx_out !== 1'b0) begin
            $display("Start bit on uart_tx_out did not last to mid-bit");
            stop_on_failure();
        end
        for (bit_idx = 0; bit_idx < 8; bit_idx++) begin
            repeat (clks_per_bit) @(negedge clk);
            captured[bit_idx] = uart_tx_out;
        end
        repeat (clks_per_bit) @(negedge clk);
        if (uart_tx_out !== 1'b1) begin
            $display("Reply byte on uart_tx_out has no valid stop bit");
            stop_on_failure();
        end
        reply_q.push_back(captured);
    end

    ////////////////////
    // Serial ADC model
    ////////////////////

    // MSB ready at chip select, next bit after each falling sclk
    always begin : adc_model
        int bit_idx;
        @(negedge adc_cs);
        frame_count++;
        #2;
        adc_data = adc_value[sample_w-1];
        for (bit_idx = sample_w - 2; bit_idx >= 0; bit_idx--) begin
            @(negedge adc_sclk);
            #2;
            adc_data = adc_value[bit_idx];
        end
    end

    always @(posedge adc_sclk) begin
        if (adc_cs === 1'b0) begin
            sclk_rises++;
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d clock cycles", cycle_count);
            stop_on_failure();
        end
    end

    ////////////////////
    // Command runner
    ////////////////////

    task automatic run_command(input logic [7:0] op, input logic [7:0] addr,
                               input logger_pkg::sample_t adc_val,
                               input logic [7:0] exp_first, input logic [7:0] exp_second);
        int                  frames_before;
        int                  rises_before;
        int                  reply_len;
        logic [7:0]          first_byte;
        logic [7:0]          second_byte;
        logger_pkg::addr_t   slot;
        logger_pkg::sample_t rebuilt;
        // Upper address bits wrap away
        slot = logger_pkg::addr_t'(addr);
        adc_value = adc_val;
        frames_before = frame_count;
        rises_before = sclk_rises;
        send_byte(op);
        // Unknown opcodes take no address byte
        if (op == 8'h53 || op == 8'h52) begin
            send_byte(addr);
        end
        reply_len = (op == 8'h52) ? 2 : 1;
        while (reply_q.size() < reply_len) begin
            @(posedge clk);
        end
        first_byte = reply_q.pop_front();
        check_reply("uart_tx_out reply byte 0", exp_first, first_byte);
        if (reply_len == 2) begin
            second_byte = reply_q.pop_front();
            check_reply("uart_tx_out reply byte 1", exp_second, second_byte);
            rebuilt = logger_pkg::sample_t'({first_byte, second_byte});
            check_sample("sample read back", model_mem[slot], rebuilt);
        end
        if (op == 8'h53) begin
            model_mem[slot] = adc_val;
            check_count("adc frames", 1, frame_count - frames_before);
            check_count("adc_sclk rising edges", sample_w, sclk_rises - rises_before);
        end else begin
            check_count("adc frames", 0, frame_count - frames_before);
            check_count("adc_sclk rising edges", 0, sclk_rises - rises_before);
        end
        // Line stays quiet for more than a byte time
        repeat (12 * clks_per_bit) @(posedge clk);
        check_count("extra reply bytes", 0, reply_q.size());
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        rst = 1'b1;
        uart_rx_in = 1'b1;
        adc_data = 1'b0;
        adc_value = '0;
        frame_count = 0;
        sclk_rises = 0;
        cycle_count = 0;
        cycle_limit = 0;
        seed = 3;

        // All ones marks the end of the file contents
        for (line_idx = 0; line_idx < line_words * max_lines; line_idx++) begin
            patterns[line_idx] = '1;
        end
        $readmemh("logger_patterns.txt", patterns);
        fixed_count = 0;
        while (fixed_count < max_lines && patterns[line_words*fixed_count] != 16'hFFFF) begin
            fixed_count++;
        end
        if (fixed_count == 0) begin
            $display("Pattern file logger_patterns.txt holds no command lines");
            stop_on_failure();
        end
        cycle_limit = (fixed_count + 2 * random_pairs)
                      * (4 * 10 * clks_per_bit + 1 + 10 * sclk_div + 20) * 2;

        // Four reset cycles, levels checked inside reset
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_idle_levels();
        @(posedge clk);
        #2;
        rst = 1'b0;

        // Idle before any command
        repeat (20) begin
            @(negedge clk);
            check_idle_levels();
        end
        check_count("adc frames before first command", 0, frame_count);

        for (line_idx = 0; line_idx < fixed_count; line_idx++) begin
            run_command(patterns[line_words*line_idx][7:0],
                        patterns[line_words*line_idx+1][7:0],
                        logger_pkg::sample_t'(patterns[line_words*line_idx+2]),
                        patterns[line_words*line_idx+3][7:0],
                        patterns[line_words*line_idx+4][7:0]);
        end

        // Random sample then read back, full address byte
        for (pair_idx = 0; pair_idx < random_pairs; pair_idx++) begin
            rand_addr = $random(seed);
            rand_sample = logger_pkg::sample_t'($random(seed));
            run_command(8'h53, rand_addr[7:0], rand_sample, 8'h4B, 8'h00);
            run_command(8'h52, rand_addr[7:0], '0,
                        {6'b000000, rand_sample[9:8]}, rand_sample[7:0]);
        end

        $display("NO ERRORS");
        $finish;
    end
endmodule

`default_nettype wire

// File: logger_patterns.txt
// Columns: opcode, address, ADC value to present, first reply byte, second reply byte
// ADC value used by samples (53) only, second reply byte by reads (52) only
53 01 2A5 4B 00
52 01 000 02 A5
53 02 155 4B 00
53 03 3FF 4B 00
53 02 0C3 4B 00
52 01 000 02 A5
52 02 000 00 C3
52 03 000 03 FF
7A 00 000 3F 00
52 13 000 03 FF
53 1F 201 4B 00
52 0F 000 02 01

// File: project.f
+incdir+.
logger_pkg.sv
logger_if.sv
uart_phy.sv
adc_sampler.sv
cmd_decode.sv
cmd_execute.sv
sample_ram.sv
reply_result.sv
logger_top.sv
tb_logger.sv

// File: Bender.yml
package:
  name: logger

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - logger_pkg.sv
      - logger_if.sv
      - uart_phy.sv
      - adc_sampler.sv
      - cmd_decode.sv
      - cmd_execute.sv
      - sample_ram.sv
      - reply_result.sv
      - logger_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_logger.sv
